// File: danmaku_config.svh
`ifndef DANMAKU_CONFIG_SVH
`define DANMAKU_CONFIG_SVH

// overlay pixel fifo, address bits and word count
// depth must stay 2**aw, pointers wrap on their own
`define OVL_FIFO_AW    4
`define OVL_FIFO_DEPTH 16

// raster counters and measured dimensions
// 16 bits leaves room for any dvi mode
`define OVL_DIM_W      16

// wishbone word address, four registers
`define WB_ADR_W       2

`endif

// File: danmaku_pkg.sv
`include "danmaku_config.svh"

package danmaku_pkg;

  // rgb888, r in the top byte like the dvi bus
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  // overlay word as written by software
  typedef struct packed {
    logic       key;   // set = replace the video pixel
    logic [6:0] rsvd;  // don't care
    pixel_t     pix;
  } ovl_word_t;

  typedef logic [`OVL_DIM_W-1:0] dim_t;  // x/y counts, width, height
  typedef logic [31:0]           wb_data_t;

  typedef enum logic [`WB_ADR_W-1:0] {
    REG_CTRL  = 2'd0,  // rw  bit0 overlay_en, bit1 test_pattern, bit2 blank
    REG_RES   = 2'd1,  // ro  height:width
    REG_FIFO  = 2'd2,  // wo  push one overlay word
    REG_FLAGS = 2'd3   // bit0 underflow, bit1 full, bit2 overflow
  } reg_addr_e;

endpackage

// File: ovl_ctrl_regs.sv
`timescale 1ns/1ps
`include "danmaku_config.svh"

module ovl_ctrl_regs (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [`WB_ADR_W-1:0]   wb_adr_i,
  input  danmaku_pkg::wb_data_t  wb_dat_i,
  output danmaku_pkg::wb_data_t  wb_dat_o,
  output logic                   wb_ack_o,
  input  danmaku_pkg::dim_t      width_i,
  input  danmaku_pkg::dim_t      height_i,
  input  logic                   full_i,
  input  logic                   underflow_i,
  output logic                   push_o,
  output danmaku_pkg::ovl_word_t push_data_o,
  output logic                   overlay_en_o,
  output logic                   test_pattern_o,
  output logic                   blank_o
);
  import danmaku_pkg::*;

  logic      req;          // cycle seen, ack not yet given
  logic      wr;
  reg_addr_e adr;
  logic      underflow_q;  // sticky
  logic      overflow_q;   // sticky
  wb_data_t  rd_data;

  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // masked during ack so ack lasts one clock
  assign wr  = req & wb_we_i;
  assign adr = reg_addr_e'(wb_adr_i);

  // ============================================================
  // read side
  // ============================================================
  always_comb
  begin
    rd_data = '0;
    case (adr)
      REG_CTRL:  rd_data = {29'd0, blank_o, test_pattern_o, overlay_en_o};
      REG_RES:   rd_data = {height_i, width_i};
      REG_FIFO:  rd_data = '0;  // push port, nothing to read
      REG_FLAGS: rd_data = {29'd0, overflow_q, full_i, underflow_q};
    endcase
  end

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end
    else
    begin
      wb_ack_o <= req;               // one clock after the request
      if (req)
        wb_dat_o <= rd_data;         // held while ack is up
    end
  end

  // ============================================================
  // mode bits and error flags
  // ============================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      overlay_en_o   <= 1'b0;
      test_pattern_o <= 1'b0;
      blank_o        <= 1'b0;
      underflow_q    <= 1'b0;
      overflow_q     <= 1'b0;
    end
    else
    begin
      if (wr && adr == REG_CTRL)
        {blank_o, test_pattern_o, overlay_en_o} <= wb_dat_i[2:0];
      // write 1 to clear, a new event in the same clock wins
      if (wr && adr == REG_FLAGS && wb_dat_i[0])
        underflow_q <= 1'b0;
      if (wr && adr == REG_FLAGS && wb_dat_i[2])
        overflow_q <= 1'b0;
      if (underflow_i)
        underflow_q <= 1'b1;
      if (wr && adr == REG_FIFO && full_i)
        overflow_q <= 1'b1;          // word dropped
    end
  end

  // fifo push, one pulse per accepted write
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
      push_o <= 1'b0;
    else
      push_o <= wr && adr == REG_FIFO && !full_i;
  end

  always_ff @(posedge odck_to_overlay)
  begin
    if (wr)
      push_data_o <= ovl_word_t'(wb_dat_i);  // lands in the fifo next edge
  end

endmodule

// File: overlay_fifo.sv
`timescale 1ns/1ps
`include "danmaku_config.svh"

module overlay_fifo (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   push_i,
  input  danmaku_pkg::ovl_word_t push_data_i,
  input  logic                   pop_i,
  output danmaku_pkg::ovl_word_t rd_data_o,
  output logic                   empty_o,
  output logic                   full_o
);
  import danmaku_pkg::*;

  localparam logic [`OVL_FIFO_AW:0] FULL_CNT = `OVL_FIFO_DEPTH;

  ovl_word_t               mem [`OVL_FIFO_DEPTH];
  logic [`OVL_FIFO_AW-1:0] wr_ptr;
  logic [`OVL_FIFO_AW-1:0] rd_ptr;
  logic [`OVL_FIFO_AW:0]   count;    // one extra bit to tell full from empty
  logic                    do_push;
  logic                    do_pop;

  assign empty_o   = (count == '0);
  assign full_o    = (count == FULL_CNT);
  assign do_push   = push_i & ~full_o;
  assign do_pop    = pop_i & ~empty_o;  // pop on empty is a no-op
  assign rd_data_o = mem[rd_ptr];       // show-ahead so the head word is always on the port

  // word storage
  always_ff @(posedge odck_to_overlay)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

// File: raster_tracker.sv
`timescale 1ns/1ps

module raster_tracker (
  input  logic              odck_to_overlay,
  input  logic              hps_fpga_reset_n,
  input  logic              vsync_i,
  input  logic              de_i,
  output danmaku_pkg::dim_t x_o,
  output danmaku_pkg::dim_t y_o,
  output danmaku_pkg::dim_t width_o,
  output danmaku_pkg::dim_t height_o
);

  logic de_q;      // de one clock back
  logic vsync_q;   // vsync one clock back
  logic de_fall;   // end of an active line
  logic vs_rise;   // start of a frame

  assign de_fall = de_q & ~de_i;
  assign vs_rise = vsync_i & ~vsync_q;

  // ============================================================
  // edge history
  // ============================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      de_q    <= 1'b0;
      vsync_q <= 1'b0;
    end
    else
    begin
      de_q    <= de_i;
      vsync_q <= vsync_i;
    end
  end

  // x is the index of the pixel on the bus right now
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      x_o     <= '0;
      width_o <= '0;
    end
    else if (de_i)
      x_o <= x_o + 1'b1;
    else if (de_fall)
    begin
      width_o <= x_o;   // de cycles in the line just ended
      x_o     <= '0;
    end
  end

  // only lines that carried de count toward y
  // first frame after reset gives a partial height
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      y_o      <= '0;
      height_o <= '0;
    end
    else if (vs_rise)
    begin
      height_o <= y_o + de_fall;  // last line may end on this same clock
      y_o      <= '0;
    end
    else if (de_fall)
      y_o <= y_o + 1'b1;
  end

endmodule

// File: overlay_mixer.sv
`timescale 1ns/1ps

module overlay_mixer (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  logic                   vsync_i,
  input  logic                   hsync_i,
  input  logic                   de_i,
  input  danmaku_pkg::pixel_t    pixel_i,
  input  danmaku_pkg::dim_t      x_i,
  input  danmaku_pkg::dim_t      y_i,
  input  logic                   overlay_en_i,
  input  logic                   test_pattern_i,
  input  logic                   blank_i,
  input  danmaku_pkg::ovl_word_t rd_data_i,
  input  logic                   empty_i,
  output logic                   pop_o,
  output logic                   underflow_o,
  output logic                   vsync_o,
  output logic                   hsync_o,
  output logic                   de_o,
  output danmaku_pkg::pixel_t    pixel_o
);
  import danmaku_pkg::*;

  pixel_t pattern;   // x/y test image
  pixel_t base;      // video or pattern
  pixel_t mixed;     // after keyed overlay
  logic   ovl_slot;  // this pixel wants an overlay word

  // ============================================================
  // pixel select
  // ============================================================
  always_comb
  begin
    pattern.r = x_i[7:0];
    pattern.g = y_i[7:0];
    pattern.b = x_i[7:0] ^ y_i[7:0];
  end

  assign base     = test_pattern_i ? pattern : pixel_i;
  assign ovl_slot = overlay_en_i & de_i;

  // one word per active pixel, consumed on this edge
  assign pop_o       = ovl_slot & ~empty_i;
  assign underflow_o = ovl_slot & empty_i;  // starved, input goes through

  // unkeyed words are consumed but leave the pixel alone
  assign mixed = (pop_o && rd_data_i.key) ? rd_data_i.pix : base;

  // ============================================================
  // output register, syncs ride along
  // ============================================================
  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      vsync_o <= 1'b0;
      hsync_o <= 1'b0;
      de_o    <= 1'b0;
      pixel_o <= '0;
    end
    else
    begin
      vsync_o <= vsync_i;
      hsync_o <= hsync_i;
      de_o    <= de_i & ~blank_i;         // blank kills de
      pixel_o <= blank_i ? '0 : mixed;    // and forces black
    end
  end

endmodule

// File: danmaku_top.sv
`timescale 1ns/1ps
`include "danmaku_config.svh"

module danmaku_top (
  input  logic                  odck_to_overlay,
  input  logic                  hps_fpga_reset_n,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`WB_ADR_W-1:0]  wb_adr_i,
  input  danmaku_pkg::wb_data_t wb_dat_i,
  output danmaku_pkg::wb_data_t wb_dat_o,
  output logic                  wb_ack_o,
  input  logic                  vsync_i,
  input  logic                  hsync_i,
  input  logic                  de_i,
  input  danmaku_pkg::pixel_t   pixel_i,
  output logic                  vsync_o,
  output logic                  hsync_o,
  output logic                  de_o,
  output danmaku_pkg::pixel_t   pixel_o
);
  import danmaku_pkg::*;

  // ============================================================
  // internal nets
  // ============================================================
  dim_t      width, height;   // measured resolution
  dim_t      x, y;            // live raster position
  logic      push, full;
  ovl_word_t push_data;
  logic      pop, empty;
  ovl_word_t rd_data;         // fifo head
  logic      underflow;
  logic      overlay_en, test_pattern, blank;

  ovl_ctrl_regs u_ctrl_regs (
    .odck_to_overlay(odck_to_overlay), .hps_fpga_reset_n(hps_fpga_reset_n),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .width_i(width), .height_i(height), .full_i(full), .underflow_i(underflow),
    .push_o(push), .push_data_o(push_data), .overlay_en_o(overlay_en),
    .test_pattern_o(test_pattern), .blank_o(blank)
  );

  overlay_fifo u_fifo (
    .odck_to_overlay(odck_to_overlay), .hps_fpga_reset_n(hps_fpga_reset_n),
    .push_i(push), .push_data_i(push_data), .pop_i(pop),
    .rd_data_o(rd_data), .empty_o(empty), .full_o(full)
  );

  raster_tracker u_raster (
    .odck_to_overlay(odck_to_overlay), .hps_fpga_reset_n(hps_fpga_reset_n),
    .vsync_i(vsync_i), .de_i(de_i),
    .x_o(x), .y_o(y), .width_o(width), .height_o(height)
  );

  // video path, one register stage
  overlay_mixer u_mixer (
    .odck_to_overlay(odck_to_overlay), .hps_fpga_reset_n(hps_fpga_reset_n),
    .vsync_i(vsync_i), .hsync_i(hsync_i), .de_i(de_i), .pixel_i(pixel_i),
    .x_i(x), .y_i(y), .overlay_en_i(overlay_en), .test_pattern_i(test_pattern),
    .blank_i(blank), .rd_data_i(rd_data), .empty_i(empty),
    .pop_o(pop), .underflow_o(underflow),
    .vsync_o(vsync_o), .hsync_o(hsync_o), .de_o(de_o), .pixel_o(pixel_o)
  );

endmodule

// File: tb_danmaku_top.sv
`timescale 1ns/1ps
`include "danmaku_config.svh"

module tb_danmaku_top;
  import danmaku_pkg::*;

  // one row of the scenario table
  typedef struct packed {
    logic [31:0] ctrl;    // value for REG_CTRL
    int          n_push;  // overlay words pushed before video
    int          w;
    int          h;
    int          hblank;  // de low cycles ahead of each line with hsync on the first two
    int          frames;
  } scen_t;

  localparam int NSCEN       = 8;
  localparam int ACK_TIMEOUT = 8;

  logic                 odck_to_overlay = 1'b0;
  logic                 hps_fpga_reset_n;
  logic                 wb_cyc_i, wb_stb_i, wb_we_i;
  logic [`WB_ADR_W-1:0] wb_adr_i;
  wb_data_t             wb_dat_i, wb_dat_o;
  logic                 wb_ack_o;
  logic                 vsync_i, hsync_i, de_i;
  logic                 vsync_o, hsync_o, de_o;
  pixel_t               pixel_i, pixel_o;

  // ============================================================
  // reference model state
  // ============================================================
  scen_t       scen [NSCEN];
  logic [31:0] fifo_q [$];        // words the fifo should hold
  logic [15:0] mx, my;            // raster position as the dut counts it
  logic        pde, pvs;          // de and vsync one clock back
  logic [2:0]  mode;              // blank test_pattern overlay_en
  logic        uf_flag, of_flag;  // sticky flags
  logic        exp_vs, exp_hs, exp_de, exp_valid;
  pixel_t      exp_pix;
  int          errors;

  always #10 odck_to_overlay = ~odck_to_overlay;  // 50 MHz

  danmaku_top u_danmaku_top (.*);

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Error at %0d ns: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic pixel_t rand_pixel();
    logic [31:0] r;
    r = $urandom;
    return r[23:0];
  endfunction

  // one classic cycle with ack exactly one clock later
  task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    begin
      @(posedge odck_to_overlay);
      #1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      n        = 0;
      rdat     = '0;
      while (!wb_ack_o && n < ACK_TIMEOUT)
      begin
        @(posedge odck_to_overlay);
        #1;
        n++;
      end
      if (!wb_ack_o)
      begin
        $display("no Wishbone ack within %0d cycles at %0d ns", ACK_TIMEOUT, $time);
        errors++;
      end
      else
      begin
        check("ack latency", 1, n);
        rdat = wb_dat_o;  // valid while ack high
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      @(posedge odck_to_overlay);
      #1;
      check("wb_ack_o", 1'b0, wb_ack_o);  // one clock wide
    end
  endtask

  // ============================================================
  // video source driving one clock per call
  // ============================================================
  task automatic video_step(input logic vs, input logic hs, input logic de, input pixel_t pix);
    pixel_t      base;
    pixel_t      mixed;
    logic [31:0] word;
    begin
      @(posedge odck_to_overlay);
      #1;
      if (exp_valid)  // outputs from the inputs of the last call
      begin
        check("vsync_o", exp_vs, vsync_o);
        check("hsync_o", exp_hs, hsync_o);
        check("de_o", exp_de, de_o);
        check("pixel_o", exp_pix, pixel_o);
      end
      if (mode[1])
        base = {mx[7:0], my[7:0], mx[7:0] ^ my[7:0]};  // r=x g=y b=x^y
      else
        base = pix;
      mixed = base;
      if (mode[0] && de)
      begin
        if (fifo_q.size() > 0)
        begin
          word = fifo_q.pop_front();
          if (word[31])
            mixed = word[23:0];  // keyed word wins
        end
        else
          uf_flag = 1'b1;        // starved
      end
      exp_vs    = vs;
      exp_hs    = hs;
      exp_de    = de & ~mode[2];
      exp_pix   = mode[2] ? '0 : mixed;
      exp_valid = 1'b1;
      // counters step on the same edge
      if (vs && !pvs)
        my = '0;
      else if (pde && !de)
        my = my + 1'b1;
      if (de)
        mx = mx + 1'b1;
      else if (pde)
        mx = '0;
      pde     = de;
      pvs     = vs;
      vsync_i = vs;
      hsync_i = hs;
      de_i    = de;
      pixel_i = pix;
    end
  endtask

  task automatic drive_frames(input scen_t s);
    for (int f = 0; f < s.frames; f++)
    begin
      video_step(1'b1, 1'b0, 1'b0, rand_pixel());  // two clocks of vsync
      video_step(1'b1, 1'b0, 1'b0, rand_pixel());
      for (int l = 0; l < s.h; l++)
      begin
        for (int c = 0; c < s.hblank; c++)
          video_step(1'b0, c < 2, 1'b0, rand_pixel());
        for (int c = 0; c < s.w; c++)
          video_step(1'b0, 1'b0, 1'b1, rand_pixel());
      end
    end
    for (int c = 0; c <= s.hblank; c++)
      video_step(1'b0, 1'b0, 1'b0, '0);  // flush so the last pixel gets checked
  endtask

  // ============================================================
  // scenario loop
  // ============================================================
  initial
  begin
    logic [31:0] rd;
    logic [31:0] word;
    word = $urandom(54769);  // seed once
    hps_fpga_reset_n = 1'b0;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
    {vsync_i, hsync_i, de_i, pixel_i} = '0;
    {mx, my, pde, pvs, mode, uf_flag, of_flag, exp_valid} = '0;
    errors = 0;
    //           ctrl   push  w   h  hbl frames
    scen[0] = '{32'h0,  0,    12, 5, 4, 2};  // plain passthrough
    scen[1] = '{32'h1,  10,   8,  3, 4, 1};  // overlay that runs dry
    scen[2] = '{32'h1,  16,   16, 1, 3, 1};  // overlay with an exact fit
    scen[3] = '{32'h2,  0,    20, 6, 5, 2};  // test pattern
    scen[4] = '{32'h3,  6,    10, 2, 4, 1};  // overlay on pattern
    scen[5] = '{32'h4,  0,    9,  3, 4, 2};  // blanked
    scen[6] = '{32'h0,  17,   0,  0, 3, 0};  // fill past full without video
    scen[7] = '{32'h1,  0,    16, 2, 4, 1};  // drain leftovers then starve
    repeat (4) @(posedge odck_to_overlay);
    #1;
    hps_fpga_reset_n = 1'b1;
    for (int i = 0; i < NSCEN; i++)
    begin
      wb_access(1'b1, REG_CTRL, scen[i].ctrl, rd);
      mode = scen[i].ctrl[2:0];
      wb_access(1'b0, REG_CTRL, 32'h0, rd);
      check("REG_CTRL", scen[i].ctrl, rd);
      for (int k = 0; k < scen[i].n_push; k++)
      begin
        word = $urandom;
        wb_access(1'b1, REG_FIFO, word, rd);
        if (fifo_q.size() < `OVL_FIFO_DEPTH)
          fifo_q.push_back(word);
        else
          of_flag = 1'b1;  // dropped
      end
      exp_valid = 1'b0;  // mode may have changed under idle video
      drive_frames(scen[i]);
      if (scen[i].frames >= 2)
      begin
        wb_access(1'b0, REG_RES, 32'h0, rd);
        check("REG_RES", (scen[i].h << 16) | scen[i].w, rd);
      end
      wb_access(1'b0, REG_FLAGS, 32'h0, rd);
      check("REG_FLAGS", {of_flag, fifo_q.size() == `OVL_FIFO_DEPTH, uf_flag}, rd);
      wb_access(1'b1, REG_FLAGS, 32'h5, rd);  // clear both sticky bits
      uf_flag = 1'b0;
      of_flag = 1'b0;
      wb_access(1'b0, REG_FLAGS, 32'h0, rd);
      check("REG_FLAGS cleared", {2'b00, fifo_q.size() == `OVL_FIFO_DEPTH, 1'b0}, rd);
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: danmaku_top.f
+incdir+.
danmaku_pkg.sv
ovl_ctrl_regs.sv
overlay_fifo.sv
raster_tracker.sv
overlay_mixer.sv
danmaku_top.sv
tb_danmaku_top.sv
